/* design/matrixTpu.sv */
`timescale 1ns/1ps

module matrixTpu (
    input  logic               clk,
    input  logic               rst,
    input  tpuPkg::opWrite_t   wrReq,
    input  logic               start,
    output logic               busy,
    output tpuPkg::resultRow_t result,
    output logic               done
);

    // Controller to loader and collector
    logic                          weightShift;
    logic [tpuPkg::IndexWidth-1:0] weightRowIdx;
    logic                          feedValid;
    logic [tpuPkg::IndexWidth-1:0] feedRowIdx;
    logic                          lastRow;

    // Loader to array, array to collector
    tpuPkg::weightRow_t weightIn;
    logic               arrayShift;
    tpuPkg::actRow_t    actIn;
    tpuPkg::sumRow_t    colSums;

    // ======================================================================
    // Sequencer and datapath
    // ======================================================================
    tpuController tpuController_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .lastRow      (lastRow),
        .busy         (busy),
        .weightShift  (weightShift),
        .weightRowIdx (weightRowIdx),
        .feedValid    (feedValid),
        .feedRowIdx   (feedRowIdx),
        .done         (done)
    );

    operandLoader operandLoader_inst (
        .clk            (clk),
        .rst            (rst),
        .wrReq          (wrReq),
        .busy           (busy),
        .weightShift    (weightShift),
        .weightRowIdx   (weightRowIdx),
        .feedValid      (feedValid),
        .feedRowIdx     (feedRowIdx),
        .weightIn       (weightIn),
        .weightShiftOut (arrayShift),
        .actIn          (actIn)
    );

    systolicArray systolicArray_inst (
        .clk         (clk),
        .rst         (rst),
        .weightIn    (weightIn),
        .weightShift (arrayShift),
        .actIn       (actIn),
        .colSums     (colSums)
    );

    resultCollector resultCollector_inst (
        .clk        (clk),
        .rst        (rst),
        .colSums    (colSums),
        .feedValid  (feedValid),
        .feedRowIdx (feedRowIdx),
        .result     (result),
        .lastRow    (lastRow)
    );

endmodule

/* design/operandLoader.sv */
`timescale 1ns/1ps

module operandLoader (
    input  logic                          clk,
    input  logic                          rst,
    input  tpuPkg::opWrite_t              wrReq,
    input  logic                          busy,
    input  logic                          weightShift,
    input  logic [tpuPkg::IndexWidth-1:0] weightRowIdx,
    input  logic                          feedValid,
    input  logic [tpuPkg::IndexWidth-1:0] feedRowIdx,
    output tpuPkg::weightRow_t            weightIn,
    output logic                          weightShiftOut,
    output tpuPkg::actRow_t               actIn
);

    // ======================================================================
    // Operand memories
    // ======================================================================
    tpuPkg::weight_t weightMem [tpuPkg::MemDepth];
    tpuPkg::act_t    actMem    [tpuPkg::MemDepth];

    always_ff @(posedge clk) begin
        if (wrReq.en && !busy) begin            // Writes during a run are dropped
            case (wrReq.sel)
                tpuPkg::WeightOperand: weightMem[wrReq.addr] <= wrReq.data;
                tpuPkg::ActOperand:    actMem[wrReq.addr] <= wrReq.data[tpuPkg::ActWidth-1:0];
            endcase
        end
    end

    // ======================================================================
    // Weight row issue
    // ======================================================================
    always_ff @(posedge clk) begin
        for (int c = 0; c < tpuPkg::ArraySize; c++) begin
            weightIn[c] <= weightMem[tpuPkg::rowAddr(weightRowIdx, c)];
        end
    end

    // Shift strobe follows the registered row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightShiftOut <= 1'b0;
        end else begin
            weightShiftOut <= weightShift;
        end
    end

    // ======================================================================
    // Activation read and diagonal skew
    // ======================================================================
    // Lane k: one read register plus k skew stages
    for (genvar k = 0; k < tpuPkg::ArraySize; k++) begin : gLane
        tpuPkg::act_t lane [0:k];

        always_ff @(posedge clk) begin
            // Idle slots carry zeros so idle column sums stay zero
            lane[0] <= feedValid ? actMem[tpuPkg::rowAddr(feedRowIdx, k)] : '0;
            for (int j = 1; j <= k; j++) begin
                lane[j] <= lane[j-1];            // Diagonal delay
            end
        end

        assign actIn[k] = lane[k];
    end

endmodule

/* design/processingElement.sv */
`timescale 1ns/1ps

module processingElement (
    input  logic            clk,
    input  logic            rst,
    input  tpuPkg::weight_t weightDown,     // From the PE above
    input  logic            weightShift,
    input  tpuPkg::act_t    actLeft,
    input  tpuPkg::sum_t    sumUp,
    output tpuPkg::weight_t weightOut,      // Stationary weight, also fed down
    output tpuPkg::act_t    actRight,
    output tpuPkg::sum_t    sumDown
);

    // Signed weight times zero-extended activation
    logic signed [tpuPkg::WeightWidth+tpuPkg::ActWidth:0] product;

    assign product = weightOut * $signed({1'b0, actLeft});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightOut <= '0;
            actRight  <= '0;
            sumDown   <= '0;
        end else begin
            if (weightShift) begin
                weightOut <= weightDown;     // Pre-load moves weights one row down
            end
            actRight <= actLeft;             // Activation moves right
            sumDown  <= sumUp + tpuPkg::sum_t'(product);
        end
    end

endmodule

/* design/resultCollector.sv */
`timescale 1ns/1ps

module resultCollector (
    input  logic                          clk,
    input  logic                          rst,
    input  tpuPkg::sumRow_t               colSums,
    input  logic                          feedValid,
    input  logic [tpuPkg::IndexWidth-1:0] feedRowIdx,
    output tpuPkg::resultRow_t            result,
    output logic                          lastRow
);

    tpuPkg::sumRow_t                 aligned;    // Deskewed row
    logic [tpuPkg::ArrayLatency-1:0] validPipe;
    logic [tpuPkg::IndexWidth-1:0]   rowPipe [tpuPkg::ArrayLatency];

    // ======================================================================
    // Column deskew
    // ======================================================================
    // Column c waits ArraySize-1-c cycles, so the last column passes through
    for (genvar c = 0; c < tpuPkg::ArraySize; c++) begin : gDeskew
        if (c == tpuPkg::ArraySize - 1) begin : gDirect
            assign aligned[c] = colSums[c];
        end else begin : gDelay
            tpuPkg::sum_t lane [0:tpuPkg::ArraySize-2-c];

            always_ff @(posedge clk) begin
                lane[0] <= colSums[c];
                for (int j = 1; j <= tpuPkg::ArraySize - 2 - c; j++) begin
                    lane[j] <= lane[j-1];
                end
            end

            assign aligned[c] = lane[tpuPkg::ArraySize-2-c];
        end
    end

    // ======================================================================
    // Valid and row index delay, matched to the datapath
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[tpuPkg::ArrayLatency-2:0], feedValid};
        end
    end

    always_ff @(posedge clk) begin
        rowPipe[0] <= feedRowIdx;
        for (int j = 1; j < tpuPkg::ArrayLatency; j++) begin
            rowPipe[j] <= rowPipe[j-1];
        end
    end

    // ReLU and output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid    <= validPipe[tpuPkg::ArrayLatency-1];
            result.rowIndex <= rowPipe[tpuPkg::ArrayLatency-1];
            for (int c = 0; c < tpuPkg::ArraySize; c++) begin
                result.data[c] <= aligned[c][tpuPkg::SumWidth-1] ? '0 : aligned[c]; // Clamp
            end
        end
    end

    assign lastRow = result.valid && (result.rowIndex == tpuPkg::LastIndex);

endmodule

/* design/systolicArray.sv */
`timescale 1ns/1ps

module systolicArray (
    input  logic               clk,
    input  logic               rst,
    input  tpuPkg::weightRow_t weightIn,
    input  logic               weightShift,
    input  tpuPkg::actRow_t    actIn,        // Row k already lags by k cycles
    output tpuPkg::sumRow_t    colSums       // Column c lags by c cycles
);

    // Edge wiring: weights and sums flow down, activations flow right
    tpuPkg::weight_t weightWire [0:tpuPkg::ArraySize][0:tpuPkg::ArraySize-1];
    tpuPkg::act_t    actWire    [0:tpuPkg::ArraySize-1][0:tpuPkg::ArraySize];
    tpuPkg::sum_t    sumWire    [0:tpuPkg::ArraySize][0:tpuPkg::ArraySize-1];

    // ======================================================================
    // Boundaries
    // ======================================================================
    for (genvar i = 0; i < tpuPkg::ArraySize; i++) begin : gEdge
        assign weightWire[0][i] = weightIn[i];                   // Top row entry
        assign sumWire[0][i]    = '0;                            // No sum above row 0
        assign actWire[i][0]    = actIn[i];                      // Left column entry
        assign colSums[i]       = sumWire[tpuPkg::ArraySize][i]; // Bottom row out
    end

    // ======================================================================
    // PE grid
    // ======================================================================
    for (genvar r = 0; r < tpuPkg::ArraySize; r++) begin : gRow
        for (genvar c = 0; c < tpuPkg::ArraySize; c++) begin : gCol
            processingElement pe_inst (
                .clk         (clk),
                .rst         (rst),
                .weightDown  (weightWire[r][c]),
                .weightShift (weightShift),
                .actLeft     (actWire[r][c]),
                .sumUp       (sumWire[r][c]),
                .weightOut   (weightWire[r+1][c]),
                .actRight    (actWire[r][c+1]),
                .sumDown     (sumWire[r+1][c])
            );
        end
    end

endmodule

/* design/tpuController.sv */
`timescale 1ns/1ps

module tpuController (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          lastRow,       // Final row on the output
    output logic                          busy,
    output logic                          weightShift,
    output logic [tpuPkg::IndexWidth-1:0] weightRowIdx,
    output logic                          feedValid,
    output logic [tpuPkg::IndexWidth-1:0] feedRowIdx,
    output logic                          done
);

    tpuPkg::ctrlState_t            state;
    logic [tpuPkg::IndexWidth-1:0] cycleCnt;     // Cycle within a phase
    logic                          phaseEnd;

    assign phaseEnd = (cycleCnt == tpuPkg::LastIndex);

    // ======================================================================
    // Run sequencer
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= tpuPkg::Idle;
            cycleCnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                tpuPkg::Idle: begin
                    cycleCnt <= '0;
                    if (start) begin
                        state <= tpuPkg::PreloadWeight;
                    end
                end
                tpuPkg::PreloadWeight: begin             // One weight row per cycle
                    cycleCnt <= cycleCnt + 1'b1;
                    if (phaseEnd) begin
                        state    <= tpuPkg::Calc;
                        cycleCnt <= '0;
                    end
                end
                tpuPkg::Calc: begin                      // One activation row per cycle
                    cycleCnt <= cycleCnt + 1'b1;
                    if (phaseEnd) begin
                        state    <= tpuPkg::Drain;
                        cycleCnt <= '0;
                    end
                end
                tpuPkg::Drain: begin
                    if (lastRow) begin
                        state <= tpuPkg::Idle;
                        done  <= 1'b1;                   // Busy falls on the same edge
                    end
                end
            endcase
        end
    end

    // Phase decodes
    assign busy         = (state != tpuPkg::Idle);
    assign weightShift  = (state == tpuPkg::PreloadWeight);
    assign weightRowIdx = tpuPkg::LastIndex - cycleCnt;  // Last row first, row 0 ends on top
    assign feedValid    = (state == tpuPkg::Calc);
    assign feedRowIdx   = cycleCnt;

endmodule

/* design/tpuPkg.sv */
package tpuPkg;

    // ======================================================================
    // Array geometry
    // ======================================================================
    localparam int ArraySize  = 4;                      // PEs per side
    localparam int MemDepth   = ArraySize * ArraySize;  // One full matrix per memory
    localparam int AddrWidth  = $clog2(MemDepth);
    localparam int IndexWidth = $clog2(ArraySize);      // Row or column index

    // Operand widths
    localparam int WeightWidth = 8;                     // Signed
    localparam int ActWidth    = 7;                     // Unsigned
    // Product plus growth for ArraySize terms
    localparam int SumWidth    = WeightWidth + ActWidth + $clog2(ArraySize);

    // Loader read, skew, array depth and deskew seen from a fed row
    localparam int ArrayLatency = 2 * ArraySize;

    localparam logic [IndexWidth-1:0] LastIndex = IndexWidth'(ArraySize - 1);

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic signed [WeightWidth-1:0] weight_t;
    typedef logic        [ActWidth-1:0]    act_t;
    typedef logic signed [SumWidth-1:0]    sum_t;

    typedef enum logic {WeightOperand, ActOperand} operandSel_t;
    typedef enum logic [1:0] {Idle, PreloadWeight, Calc, Drain} ctrlState_t;

    typedef struct packed {
        logic                   en;
        operandSel_t            sel;
        logic [AddrWidth-1:0]   addr;
        logic [WeightWidth-1:0] data;    // Activations use the low bits
    } opWrite_t;

    typedef weight_t [ArraySize-1:0] weightRow_t;
    typedef act_t    [ArraySize-1:0] actRow_t;
    typedef sum_t    [ArraySize-1:0] sumRow_t;

    typedef struct packed {
        logic                  valid;
        logic [IndexWidth-1:0] rowIndex;
        sumRow_t               data;
    } resultRow_t;

    // Element address of (row, col) in a row-major operand memory
    function automatic logic [AddrWidth-1:0] rowAddr(input logic [IndexWidth-1:0] row,
                                                     input int col);
        return AddrWidth'(row * ArraySize + col);
    endfunction

endpackage

/* filelist.f */
design/tpuPkg.sv
design/processingElement.sv
design/operandLoader.sv
design/systolicArray.sv
design/resultCollector.sv
design/tpuController.sv
design/matrixTpu.sv
verification/matrixTpuTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module matrixTpuTb -o matrixTpuSim &&
./obj_dir/matrixTpuSim | grep -F 'All tests passed!' &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* verification/matrixTpuTb.sv */
`timescale 1ns/1ps

module matrixTpuTb;

    localparam int N             = tpuPkg::ArraySize;
    localparam int NumTests      = 5;
    localparam int ResetCycles   = 8;
    localparam int RunCycles     = 5 * N;                   // Preload, feed, latency, done
    localparam int TimeoutCycles = (2 * tpuPkg::MemDepth + RunCycles) * NumTests * 2;
    localparam int RowWaitLimit  = 4 * N + 8;               // Start to first valid row with margin

    logic               clk;
    logic               rst;
    tpuPkg::opWrite_t   wrReq;
    logic               start;
    logic               busy;
    tpuPkg::resultRow_t result;
    logic               done;

    // Testbench copies of the operands and the expected result
    int    weightModel [N][N];      // [k][c]
    int    actModel    [N][N];      // [r][k]
    int    expected    [N][N];      // [r][c]
    string testName = "reset";
    int    cycleCount = 0;

    matrixTpu matrixTpu_inst (
        .clk    (clk),
        .rst    (rst),
        .wrReq  (wrReq),
        .start  (start),
        .busy   (busy),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    // ======================================================================
    // Failure reporting
    // ======================================================================
    task automatic haltOnFailure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic failWith(input string reason);
        $display("%s: %s", testName, reason);
        haltOnFailure();
    endtask

    task automatic reportMismatch(input int r, input int c, input int exp, input int act);
        $display("ERROR %s: row %0d col %0d expected %0d, actual %0d", testName, r, c, exp, act);
        haltOnFailure();
    endtask

    // Run limit from the total length of all tests
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failWith("timeout, the tests did not finish in time");
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    function automatic int randomWeight();
        return int'($urandom % 256) - 128;          // Full signed range
    endfunction

    function automatic int randomAct(input int minValue);
        return minValue + int'($urandom % (128 - minValue));
    endfunction

    task automatic writeOperand(input tpuPkg::operandSel_t sel, input int addr, input int value);
        tpuPkg::opWrite_t req;
        req.en   = 1'b1;
        req.sel  = sel;
        req.addr = tpuPkg::AddrWidth'(addr);
        req.data = tpuPkg::WeightWidth'(value);     // Two's complement for weights
        @(posedge clk);
        wrReq <= req;
    endtask

    task automatic releaseBus();
        @(posedge clk);
        wrReq <= '0;
    endtask

    task automatic loadWeights();
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                writeOperand(tpuPkg::WeightOperand, k * N + c, weightModel[k][c]);
            end
        end
        releaseBus();
    endtask

    task automatic loadActivations();
        for (int r = 0; r < N; r++) begin
            for (int k = 0; k < N; k++) begin
                writeOperand(tpuPkg::ActOperand, r * N + k, actModel[r][k]);
            end
        end
        releaseBus();
    endtask

    task automatic randomActivations(input int minValue);
        for (int r = 0; r < N; r++) begin
            for (int k = 0; k < N; k++) begin
                actModel[r][k] = randomAct(minValue);
            end
        end
    endtask

    // Reference model of ReLU over activations times weights
    task automatic computeExpected();
        int sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = 0;
                for (int k = 0; k < N; k++) begin
                    sum += actModel[r][k] * weightModel[k][c];
                end
                expected[r][c] = (sum < 0) ? 0 : sum;
            end
        end
    endtask

    // ======================================================================
    // Run sequencing and result checks
    // ======================================================================
    task automatic launchRun();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (busy) else failWith("busy did not rise after start");
    endtask

    task automatic collectRows();
        int waitCycles;
        int actual;
        waitCycles = 0;
        while (!result.valid) begin                 // No fixed latency assumed
            assert (!done) else failWith("done pulsed before any result row");
            assert (waitCycles < RowWaitLimit) else failWith("no result row arrived");
            @(negedge clk);
            waitCycles++;
        end
        for (int r = 0; r < N; r++) begin
            if (r > 0) begin
                @(negedge clk);
            end
            assert (result.valid) else failWith("result rows not on consecutive cycles");
            assert (result.rowIndex == tpuPkg::IndexWidth'(r))
                else failWith("result row arrived out of order");
            assert (!done) else failWith("done pulsed before the last row");
            for (int c = 0; c < N; c++) begin
                actual = int'(result.data[c]);
                assert (actual == expected[r][c]) else reportMismatch(r, c, expected[r][c], actual);
            end
        end
        @(negedge clk);
        assert (done) else failWith("done did not follow the last row");
        assert (!busy) else failWith("busy still high when done pulsed");
        assert (!result.valid) else failWith("extra result row after the last one");
    endtask

    task automatic runAndCheck();
        computeExpected();
        launchRun();
        collectRows();
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic identityWeights();
        testName = "identityWeights";
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                weightModel[k][c] = (k == c) ? 1 : 0;
            end
        end
        randomActivations(0);
        loadWeights();
        loadActivations();
        runAndCheck();                              // Result is the activation matrix
    endtask

    task automatic randomSigned();
        testName = "randomSigned";
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                weightModel[k][c] = randomWeight();
            end
        end
        randomActivations(0);
        for (int k = 0; k < N; k++) begin
            weightModel[k][0] = 127;                // Largest positive sum lands at (0, 0)
            actModel[0][k]    = 127;
        end
        loadWeights();
        loadActivations();
        runAndCheck();
    endtask

    task automatic weightsKept();
        testName = "weightsKept";
        randomActivations(0);
        loadActivations();                          // Weights left from the last run
        runAndCheck();
    endtask

    task automatic reluClamp();
        testName = "reluClamp";
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                weightModel[k][c] = -1 - int'($urandom % 128);
            end
        end
        randomActivations(1);                       // Nonzero so every sum is negative
        loadWeights();
        loadActivations();
        runAndCheck();
    endtask

    task automatic busyWritesDropped();
        testName = "busyWritesDropped";
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                weightModel[k][c] = randomWeight();
            end
        end
        randomActivations(0);
        loadWeights();
        loadActivations();
        computeExpected();
        launchRun();
        for (int a = 0; a < N; a++) begin
            assert (busy) else failWith("busy fell while writes were still issued");
            writeOperand(tpuPkg::WeightOperand, a, ~weightModel[0][a]);   // Differs from model
        end
        releaseBus();
        collectRows();
        runAndCheck();                              // Second run must still see the old weights
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h9c3e));
        rst   = 1'b1;
        start = 1'b0;
        wrReq = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy && !done && !result.valid) else failWith("outputs not idle after reset");

        identityWeights();
        randomSigned();
        weightsKept();
        reluClamp();
        busyWritesDropped();

        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule
